//--- Bender.yml
package:
  name: instr_fetch

sources:
  - files:
      - verilog/fetch_pkg.sv
      - verilog/rvc_pkg.sv
      - verilog/fetch_word_if.sv
      - verilog/parcel_if.sv
      - verilog/fetch_pc_gen.sv
      - verilog/parcel_realign_buf.sv
      - verilog/rvc_expander.sv
      - verilog/instr_fetch_top.sv
  - target: simulation
    files:
      - verification/tb_instr_fetch_top.sv

//--- instr_fetch_top.f
verilog/fetch_pkg.sv
verilog/rvc_pkg.sv
verilog/fetch_word_if.sv
verilog/parcel_if.sv
verilog/fetch_pc_gen.sv
verilog/parcel_realign_buf.sv
verilog/rvc_expander.sv
verilog/instr_fetch_top.sv
verification/tb_instr_fetch_top.sv

//--- verification/tb_instr_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_instr_fetch_top;
    import fetch_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int IMG_HW         = 32;  // program image in halfwords
    localparam int MAX_ROWS       = 16;
    localparam int REDIR_ROW      = 7;   // 32-bit entry at a halfword offset of 2

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        imem_req_valid_o;
    logic        imem_req_ready_i;
    logic [31:0] imem_addr_o;
    logic        imem_rsp_valid_i;
    logic [31:0] imem_rsp_data_i;
    logic        redirect_valid_i;
    logic [31:1] redirect_pc_i;
    logic        dec_valid_o;
    logic        dec_ready_i;
    logic [31:0] dec_instr_o;
    logic [31:1] dec_pc_o;
    logic        dec_illegal_o;

    logic [31:0] lfsr_state = 32'h9960_3cc4;
    logic [15:0] image [IMG_HW];
    logic [31:0] row_pc  [MAX_ROWS];
    logic [31:0] row_exp [MAX_ROWS];
    logic        row_ill [MAX_ROWS];
    int          n_rows = 0;
    logic [31:0] next_pc = RESET_PC;

    logic [31:0] pend_addr [$];  // accepted requests with the oldest first
    int          pend_due  [$];
    logic        first_req_seen = 1'b0;
    logic [31:0] first_req_addr;

    logic        held = 1'b0;    // decode output was stalled at the last edge
    logic [31:0] held_instr;
    logic [31:1] held_pc;
    logic        timed_out = 1'b0;
    int          n_errors = 0;
    int          n_checks = 0;

    instr_fetch_top uut (.*);

    initial begin : clock_gen
        forever #4 clk_i = ~clk_i;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] fill_hw(input logic [31:0] a);
        return a[31:16] ^ a[15:0] ^ 16'h5a3c;
    endfunction

    function automatic logic [15:0] hw_at(input logic [31:0] a);
        logic [31:0] off;
        off = a - RESET_PC;
        if (a >= RESET_PC && off < 2 * IMG_HW)
            return image[off >> 1];
        return fill_hw(a);
    endfunction

    // lays one table row into the image right after the previous one
    task automatic add_row(input logic [31:0] raw, input int len,
                           input logic [31:0] exp, input logic ill);
        int hw;
        hw = (next_pc - RESET_PC) / 2;
        image[hw] = raw[15:0];
        if (len == 4)
            image[hw + 1] = raw[31:16];
        row_pc[n_rows]  = next_pc;
        row_exp[n_rows] = exp;
        row_ill[n_rows] = ill;
        next_pc = next_pc + len;
        n_rows++;
    endtask

    // waits for one decode transfer and checks it against a table row
    task automatic expect_row(input int idx);
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        while (!done && !timed_out) begin
            @(posedge clk_i);
            if (held) begin
                assert (dec_valid_o && dec_instr_o == held_instr && dec_pc_o == held_pc)
                else begin
                    n_errors++;
                    $display("ERROR %0t: decode output changed while stalled", $time);
                end
            end
            held       = dec_valid_o && !dec_ready_i;
            held_instr = dec_instr_o;
            held_pc    = dec_pc_o;
            if (dec_valid_o && dec_ready_i) begin
                done = 1'b1;
                n_checks++;
                assert ({dec_pc_o, 1'b0} == row_pc[idx] && dec_instr_o == row_exp[idx]
                        && dec_illegal_o == row_ill[idx])
                else begin
                    n_errors++;
                    $display("ERROR %0t: entry %0d got pc %h instr %h ill %b, expected %h %h %b",
                             $time, idx, {dec_pc_o, 1'b0}, dec_instr_o, dec_illegal_o,
                             row_pc[idx], row_exp[idx], row_ill[idx]);
                end
            end else begin
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    timed_out = 1'b1;
                    $display("Timed out waiting for decode to deliver table entry %0d", idx);
                end
            end
        end
    endtask

    // memory model plus the random inputs driven 1 ns after the edge
    initial begin : stimulus
        int cycle;
        int due;
        cycle = 0;
        forever begin
            @(posedge clk_i);
            cycle++;
            if (imem_req_valid_o && imem_req_ready_i) begin
                if (!first_req_seen) begin
                    first_req_seen = 1'b1;
                    first_req_addr = imem_addr_o;
                end
                due = cycle + 1 + next_rand_bit() + next_rand_bit();  // 1 to 3 cycles
                if (pend_due.size() > 0 && due <= pend_due[pend_due.size() - 1])
                    due = pend_due[pend_due.size() - 1] + 1;  // keep responses in order
                pend_addr.push_back(imem_addr_o);
                pend_due.push_back(due);
            end
            #1;
            if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
                imem_rsp_valid_i = 1'b1;
                imem_rsp_data_i  = {hw_at(pend_addr[0] + 2), hw_at(pend_addr[0])};
                void'(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end else begin
                imem_rsp_valid_i = 1'b0;
            end
            imem_req_ready_i = next_rand_bit() | next_rand_bit();
            dec_ready_i      = next_rand_bit();
        end
    end

    initial begin : main
        int i;
        int waited;
        rst_n_i          = 1'b0;
        imem_req_ready_i = 1'b0;
        imem_rsp_valid_i = 1'b0;
        imem_rsp_data_i  = '0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        dec_ready_i      = 1'b0;
        for (i = 0; i < IMG_HW; i++)
            image[i] = fill_hw(RESET_PC + 2 * i);

        add_row(32'h0050_0093, 4, 32'h0050_0093, 1'b0);  // addi x1, x0, 5
        add_row(32'h0000_450d, 2, 32'h0030_0513, 1'b0);  // c.li x10, 3
        add_row(32'h0020_81b3, 4, 32'h0020_81b3, 1'b0);  // add x3, x1, x2 across words
        add_row(32'h0000_85aa, 2, 32'h00a0_05b3, 1'b0);  // c.mv x11, x10
        add_row(32'h0000_147d, 2, 32'hfff4_0413, 1'b0);  // c.addi x8, -1
        add_row(32'h0000_4144, 2, 32'h0045_2483, 1'b0);  // c.lw x9, 4(x10)
        add_row(32'h0000_0000, 2, 32'h0000_0000, 1'b1);  // all-zero parcel
        add_row(32'h1234_52b7, 4, 32'h1234_52b7, 1'b0);  // lui x5, 0x12345 across words
        add_row(32'h0000_4002, 2, 32'h0000_4002, 1'b1);  // c.lwsp with rd zero
        add_row(32'h0000_908a, 2, 32'h0020_80b3, 1'b0);  // c.add x1, x2
        add_row(32'h0000_0612, 2, 32'h0046_1613, 1'b0);  // c.slli x12, 4
        add_row(32'h0031_2023, 4, 32'h0031_2023, 1'b0);  // sw x3, 0(x2)
        add_row(32'h0000_8a9d, 2, 32'h0076_f693, 1'b0);  // c.andi x13, 7
        add_row(32'h0000_0001, 2, 32'h0000_0013, 1'b0);  // c.nop

        repeat (8) begin
            @(posedge clk_i);
            #1;
            assert (!dec_valid_o && !imem_req_valid_o) else begin
                n_errors++;
                $display("ERROR %0t: valid output high during reset", $time);
            end
        end
        rst_n_i = 1'b1;

        for (i = 0; i < n_rows && !timed_out; i++)
            expect_row(i);

        assert (first_req_seen) else begin
            n_errors++;
            $display("No memory request was ever accepted");
        end
        assert (!first_req_seen || first_req_addr == RESET_PC) else begin
            n_errors++;
            $display("ERROR %0t: first request at %h, expected %h",
                     $time, first_req_addr, RESET_PC);
        end

        // redirect while the request just accepted is still in flight
        waited = 0;
        while (!timed_out) begin
            @(posedge clk_i);
            if (imem_req_valid_o && imem_req_ready_i)
                break;
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                timed_out = 1'b1;
                $display("Timed out waiting for a memory request before the redirect");
            end
        end
        if (!timed_out) begin
            #1;
            redirect_valid_i = 1'b1;
            redirect_pc_i    = row_pc[REDIR_ROW][31:1];
            @(posedge clk_i);
            #1 redirect_valid_i = 1'b0;
            held = 1'b0;
            for (i = REDIR_ROW; i < n_rows && !timed_out; i++)
                expect_row(i);
        end

        $display("%0d checks, %0d errors, timeout %0d", n_checks, n_errors, timed_out);
        if (n_errors == 0 && !timed_out)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           redirect_valid_i,
    input  logic [31:1]    redirect_pc_i,
    output logic           imem_req_valid_o,
    input  logic           imem_req_ready_i,
    output logic [31:0]    imem_addr_o,
    input  logic           imem_rsp_valid_i,
    input  logic [31:0]    imem_rsp_data_i,
    fetch_word_if.producer word_o
);
    import fetch_pkg::*;

    logic [31:1]      pc_q;        // next request, halfword address
    logic [31:1]      rsp_pc_q;    // tag for the next live response
    logic             run_q;
    logic [CNT_W-1:0] inflight_q;  // includes stale ones
    logic [CNT_W-1:0] stale_q;
    logic [CNT_W-1:0] q_cnt_q;
    logic             q_wr_q;
    logic             q_rd_q;
    fetch_word_t      q_mem [MAX_OUTSTANDING];

    logic             req_fire;
    logic             rsp_live;
    logic             pop;
    logic [CNT_W:0]   occupancy;
    logic [CNT_W-1:0] inflight_nxt;

    // never ask for more than the queue can always absorb
    assign occupancy        = {1'b0, inflight_q} + {1'b0, q_cnt_q};
    assign imem_req_valid_o = run_q && (occupancy < (CNT_W + 1)'(MAX_OUTSTANDING));
    assign imem_addr_o      = {pc_q[31:2], 2'b00};
    assign req_fire         = imem_req_valid_o && imem_req_ready_i;

    assign rsp_live = imem_rsp_valid_i && (stale_q == '0);
    assign pop      = word_o.valid && word_o.ready;

    assign inflight_nxt = inflight_q + CNT_W'(req_fire) - CNT_W'(imem_rsp_valid_i);

    assign word_o.valid = (q_cnt_q != '0);
    assign word_o.word  = q_mem[q_rd_q].word;
    assign word_o.pc    = q_mem[q_rd_q].pc;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q      <= 1'b0;
            pc_q       <= RESET_PC[31:1];
            rsp_pc_q   <= RESET_PC[31:1];
            inflight_q <= '0;
            stale_q    <= '0;
            q_cnt_q    <= '0;
            q_wr_q     <= 1'b0;
            q_rd_q     <= 1'b0;
        end else begin
            run_q      <= 1'b1;
            inflight_q <= inflight_nxt;
            if (redirect_valid_i) begin
                pc_q     <= redirect_pc_i;
                rsp_pc_q <= redirect_pc_i;
                stale_q  <= inflight_nxt;  // whatever is still out gets dropped
                q_cnt_q  <= '0;
                q_wr_q   <= 1'b0;
                q_rd_q   <= 1'b0;
            end else begin
                if (req_fire)
                    pc_q <= {pc_q[31:2] + 30'd1, 1'b0};  // next word boundary
                if (imem_rsp_valid_i && !rsp_live)
                    stale_q <= stale_q - CNT_W'(1);
                if (rsp_live) begin
                    rsp_pc_q <= {rsp_pc_q[31:2] + 30'd1, 1'b0};
                    q_wr_q   <= ~q_wr_q;
                end
                if (pop)
                    q_rd_q <= ~q_rd_q;
                q_cnt_q <= q_cnt_q + CNT_W'(rsp_live) - CNT_W'(pop);
            end
        end
    end

    // response queue storage
    always_ff @(posedge clk_i) begin
        if (rsp_live)
            q_mem[q_wr_q] <= '{word: imem_rsp_data_i, pc: rsp_pc_q};
    end

endmodule

`default_nettype wire

//--- verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // fetch restarts here after reset
    localparam logic [31:0] RESET_PC = 32'h0000_1000;

    // requests in flight plus words waiting in the producer queue
    localparam int MAX_OUTSTANDING = 2;
    localparam int CNT_W           = 2;  // wide enough for MAX_OUTSTANDING

    // realignment buffer depth in 16-bit parcels
    localparam int PARCEL_SLOTS = 4;
    localparam int SLOT_W       = 2;     // slot index

    // one fetched word tagged with the halfword pc of its first useful parcel
    typedef struct packed {
        logic [31:0] word;
        logic [31:1] pc;
    } fetch_word_t;

endpackage

`default_nettype wire

//--- verilog/fetch_word_if.sv
`timescale 1ns/1ps
`default_nettype none

// fetched words, PC generator -> realignment buffer
interface fetch_word_if;

    logic        valid;
    logic        ready;
    logic [31:0] word;
    logic [31:1] pc;     // bit 1 set means lower parcel is skipped

    modport producer (
        output valid, word, pc,
        input  ready
    );

    modport buffer (
        input  valid, word, pc,
        output ready
    );

endinterface

`default_nettype wire

//--- verilog/instr_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch_top (
    input  logic        clk_i,
    input  logic        rst_n_i,
    // instruction memory
    output logic        imem_req_valid_o,
    input  logic        imem_req_ready_i,
    output logic [31:0] imem_addr_o,
    input  logic        imem_rsp_valid_i,
    input  logic [31:0] imem_rsp_data_i,
    // redirect from execute
    input  logic        redirect_valid_i,
    input  logic [31:1] redirect_pc_i,
    // decode
    output logic        dec_valid_o,
    input  logic        dec_ready_i,
    output logic [31:0] dec_instr_o,
    output logic [31:1] dec_pc_o,
    output logic        dec_illegal_o
);

    fetch_word_if fetch_word ();
    parcel_if     parcel ();

    fetch_pc_gen u_pc_gen (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .imem_req_valid_o (imem_req_valid_o),
        .imem_req_ready_i (imem_req_ready_i),
        .imem_addr_o      (imem_addr_o),
        .imem_rsp_valid_i (imem_rsp_valid_i),
        .imem_rsp_data_i  (imem_rsp_data_i),
        .word_o           (fetch_word.producer)
    );

    // redirect flushes every stage in the same cycle
    parcel_realign_buf u_realign (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (redirect_valid_i),
        .word_i  (fetch_word.buffer),
        .instr_o (parcel.buffer)
    );

    rvc_expander u_expander (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (redirect_valid_i),
        .instr_i       (parcel.expander),
        .dec_valid_o   (dec_valid_o),
        .dec_ready_i   (dec_ready_i),
        .dec_instr_o   (dec_instr_o),
        .dec_pc_o      (dec_pc_o),
        .dec_illegal_o (dec_illegal_o)
    );

endmodule

`default_nettype wire

//--- verilog/parcel_if.sv
`timescale 1ns/1ps
`default_nettype none

// whole raw instructions, realignment buffer -> expander
interface parcel_if;

    logic        valid;
    logic        ready;
    logic [31:0] instr;       // upper half zero when compressed
    logic [31:1] pc;
    logic        compressed;

    modport buffer (
        output valid, instr, pc, compressed,
        input  ready
    );

    modport expander (
        input  valid, instr, pc, compressed,
        output ready
    );

endinterface

`default_nettype wire

//--- verilog/parcel_realign_buf.sv
`timescale 1ns/1ps
`default_nettype none

module parcel_realign_buf (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,
    fetch_word_if.buffer word_i,
    parcel_if.buffer     instr_o
);
    import fetch_pkg::*;

    // circular parcel store, each parcel keeps its own pc
    logic [15:0]       parcel_q [PARCEL_SLOTS];
    logic [31:1]       ppc_q    [PARCEL_SLOTS];
    logic [SLOT_W-1:0] rd_ptr_q;
    logic [SLOT_W-1:0] wr_ptr_q;
    logic [SLOT_W:0]   cnt_q;

    logic [SLOT_W-1:0] wr_ptr_1;
    logic [SLOT_W-1:0] rd_ptr_1;
    logic [SLOT_W:0]   free_slots;
    logic [SLOT_W:0]   n_in;
    logic [SLOT_W:0]   n_out;
    logic              skip_lo;
    logic              push;
    logic              pop;
    logic [15:0]       head;
    logic              head_comp;

    assign skip_lo    = word_i.pc[1];  // word entered mid-way
    assign n_in       = (SLOT_W + 1)'(skip_lo ? 1 : 2);
    assign free_slots = (SLOT_W + 1)'(PARCEL_SLOTS) - cnt_q;
    assign word_i.ready = (free_slots >= n_in);
    assign push       = word_i.valid && word_i.ready;

    assign wr_ptr_1 = wr_ptr_q + SLOT_W'(1);
    assign rd_ptr_1 = rd_ptr_q + SLOT_W'(1);

    // length decode on the head parcel
    assign head      = parcel_q[rd_ptr_q];
    assign head_comp = (head[1:0] != 2'b11);
    assign n_out     = (SLOT_W + 1)'(head_comp ? 1 : 2);

    // a 32-bit instruction waits here until its upper half arrives
    assign instr_o.valid      = (cnt_q != '0) && (head_comp || cnt_q >= (SLOT_W + 1)'(2));
    assign instr_o.instr      = head_comp ? {16'h0000, head} : {parcel_q[rd_ptr_1], head};
    assign instr_o.pc         = ppc_q[rd_ptr_q];
    assign instr_o.compressed = head_comp;
    assign pop                = instr_o.valid && instr_o.ready;

    always_ff @(posedge clk_i) begin
        if (push) begin
            ppc_q[wr_ptr_q] <= word_i.pc;
            if (skip_lo) begin
                parcel_q[wr_ptr_q] <= word_i.word[31:16];
            end else begin
                parcel_q[wr_ptr_q] <= word_i.word[15:0];
                parcel_q[wr_ptr_1] <= word_i.word[31:16];
                ppc_q[wr_ptr_1]    <= {word_i.pc[31:2], 1'b1};
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin  // redirect wins over any transfer
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push)
                wr_ptr_q <= wr_ptr_q + n_in[SLOT_W-1:0];
            if (pop)
                rd_ptr_q <= rd_ptr_q + n_out[SLOT_W-1:0];
            cnt_q <= cnt_q + (push ? n_in : '0) - (pop ? n_out : '0);
        end
    end

endmodule

`default_nettype wire

//--- verilog/rvc_expander.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_expander (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        flush_i,
    parcel_if.expander  instr_i,
    output logic        dec_valid_o,
    input  logic        dec_ready_i,
    output logic [31:0] dec_instr_o,
    output logic [31:1] dec_pc_o,
    output logic        dec_illegal_o
);
    import rvc_pkg::*;

    logic [15:0] c;
    logic [4:0]  rd;      // also rs1 in full-register forms
    logic [4:0]  rs2;
    logic [4:0]  rdp;     // rd' / rs2'
    logic [4:0]  rs1p;
    logic [11:0] imm6;    // sign-extended 6-bit immediate
    logic [19:0] j_imm;   // jal imm field, already in instruction order
    rvc_op_e     op;
    logic [31:0] exp_instr;
    logic        load;

    assign c     = instr_i.instr[15:0];
    assign rd    = c[11:7];
    assign rs2   = c[6:2];
    assign rdp   = {CREG_BASE, c[4:2]};
    assign rs1p  = {CREG_BASE, c[9:7]};
    assign imm6  = {{7{c[12]}}, c[6:2]};
    assign j_imm = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], c[12], {8{c[12]}}};

    // classify by quadrant and funct3
    always_comb begin
        op = C_ILLEGAL;
        case ({c[1:0], c[15:13]})
            5'b00_000: op = (c[12:5] != '0) ? C_ADDI4SPN : C_ILLEGAL;  // covers all-zero
            5'b00_010: op = C_LW;
            5'b00_110: op = C_SW;
            5'b01_000: op = C_ADDI;
            5'b01_001: op = C_JAL;
            5'b01_010: op = C_LI;
            5'b01_011: begin
                if ({c[12], c[6:2]} == '0)
                    op = C_ILLEGAL;
                else
                    op = (rd == REG_SP) ? C_ADDI16SP : C_LUI;
            end
            5'b01_100: begin
                case (c[11:10])
                    2'b00:   op = c[12] ? C_ILLEGAL : C_SRLI;  // shamt[5] is rv64 only
                    2'b01:   op = c[12] ? C_ILLEGAL : C_SRAI;
                    2'b10:   op = C_ANDI;
                    default: begin
                        if (!c[12]) begin
                            case (c[6:5])
                                2'b00:   op = C_SUB;
                                2'b01:   op = C_XOR;
                                2'b10:   op = C_OR;
                                default: op = C_AND;
                            endcase
                        end
                    end
                endcase
            end
            5'b01_101: op = C_J;
            5'b01_110: op = C_BEQZ;
            5'b01_111: op = C_BNEZ;
            5'b10_000: op = c[12] ? C_ILLEGAL : C_SLLI;
            5'b10_010: op = (rd != '0) ? C_LWSP : C_ILLEGAL;
            5'b10_100: begin
                if (!c[12])
                    op = (rs2 != '0) ? C_MV : ((rd != '0) ? C_JR : C_ILLEGAL);
                else if (rs2 != '0)
                    op = C_ADD;
                else
                    op = (rd != '0) ? C_JALR : C_EBREAK;
            end
            5'b10_110: op = C_SWSP;
            default:   op = C_ILLEGAL;  // float and reserved slots
        endcase
    end

    // standard RV32C to RV32I mapping
    always_comb begin
        case (op)
            C_ADDI4SPN: exp_instr = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                                     REG_SP, 3'b000, rdp, OPC_OP_IMM};
            C_LW:       exp_instr = {5'b0, c[5], c[12:10], c[6], 2'b00,
                                     rs1p, 3'b010, rdp, OPC_LOAD};
            C_SW:       exp_instr = {5'b0, c[5], c[12], rdp, rs1p, 3'b010,
                                     c[11:10], c[6], 2'b00, OPC_STORE};
            C_ADDI:     exp_instr = {imm6, rd, 3'b000, rd, OPC_OP_IMM};
            C_JAL:      exp_instr = {j_imm, REG_RA, OPC_JAL};
            C_LI:       exp_instr = {imm6, 5'd0, 3'b000, rd, OPC_OP_IMM};
            C_ADDI16SP: exp_instr = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000,
                                     REG_SP, 3'b000, REG_SP, OPC_OP_IMM};
            C_LUI:      exp_instr = {{15{c[12]}}, c[6:2], rd, OPC_LUI};
            C_SRLI:     exp_instr = {7'b0000000, rs2, rs1p, 3'b101, rs1p, OPC_OP_IMM};
            C_SRAI:     exp_instr = {7'b0100000, rs2, rs1p, 3'b101, rs1p, OPC_OP_IMM};
            C_ANDI:     exp_instr = {imm6, rs1p, 3'b111, rs1p, OPC_OP_IMM};
            C_SUB:      exp_instr = {7'b0100000, rdp, rs1p, 3'b000, rs1p, OPC_OP};
            C_XOR:      exp_instr = {7'b0000000, rdp, rs1p, 3'b100, rs1p, OPC_OP};
            C_OR:       exp_instr = {7'b0000000, rdp, rs1p, 3'b110, rs1p, OPC_OP};
            C_AND:      exp_instr = {7'b0000000, rdp, rs1p, 3'b111, rs1p, OPC_OP};
            C_J:        exp_instr = {j_imm, 5'd0, OPC_JAL};
            C_BEQZ:     exp_instr = {{4{c[12]}}, c[6:5], c[2], 5'd0, rs1p, 3'b000,
                                     c[11:10], c[4:3], c[12], OPC_BRANCH};
            C_BNEZ:     exp_instr = {{4{c[12]}}, c[6:5], c[2], 5'd0, rs1p, 3'b001,
                                     c[11:10], c[4:3], c[12], OPC_BRANCH};
            C_SLLI:     exp_instr = {7'b0000000, rs2, rd, 3'b001, rd, OPC_OP_IMM};
            C_LWSP:     exp_instr = {4'b0, c[3:2], c[12], c[6:4], 2'b00,
                                     REG_SP, 3'b010, rd, OPC_LOAD};
            C_JR:       exp_instr = {12'd0, rd, 3'b000, 5'd0, OPC_JALR};
            C_MV:       exp_instr = {7'b0000000, rs2, 5'd0, 3'b000, rd, OPC_OP};
            C_EBREAK:   exp_instr = {12'd1, 5'd0, 3'b000, 5'd0, OPC_SYSTEM};
            C_JALR:     exp_instr = {12'd0, rd, 3'b000, REG_RA, OPC_JALR};
            C_ADD:      exp_instr = {7'b0000000, rs2, rd, 3'b000, rd, OPC_OP};
            C_SWSP:     exp_instr = {4'b0, c[8:7], c[12], rs2, REG_SP, 3'b010,
                                     c[11:9], 2'b00, OPC_STORE};
            default:    exp_instr = {16'h0000, c};  // raw parcel, flagged illegal
        endcase
    end

    // output register takes a new instruction when empty or being drained
    assign instr_i.ready = !dec_valid_o || dec_ready_i;
    assign load          = instr_i.valid && instr_i.ready;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i)
            dec_valid_o <= 1'b0;
        else if (flush_i)
            dec_valid_o <= 1'b0;
        else if (load)
            dec_valid_o <= 1'b1;
        else if (dec_ready_i)
            dec_valid_o <= 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            dec_instr_o   <= instr_i.compressed ? exp_instr : instr_i.instr;
            dec_pc_o      <= instr_i.pc;
            dec_illegal_o <= instr_i.compressed && (op == C_ILLEGAL);
        end
    end

endmodule

`default_nettype wire

//--- verilog/rvc_pkg.sv
`default_nettype none

package rvc_pkg;

    // supported compressed operations, RV32C without float forms
    typedef enum logic [4:0] {
        C_ADDI4SPN, C_LW,     C_SW,
        C_ADDI,     C_JAL,    C_LI,     C_ADDI16SP, C_LUI,
        C_SRLI,     C_SRAI,   C_ANDI,
        C_SUB,      C_XOR,    C_OR,     C_AND,
        C_J,        C_BEQZ,   C_BNEZ,
        C_SLLI,     C_LWSP,   C_JR,     C_MV,
        C_EBREAK,   C_JALR,   C_ADD,    C_SWSP,
        C_ILLEGAL
    } rvc_op_e;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [4:0] REG_SP = 5'd2;
    localparam logic [4:0] REG_RA = 5'd1;

    // rd'/rs1'/rs2' prefix, x8..x15
    localparam logic [1:0] CREG_BASE = 2'b01;

endpackage

`default_nettype wire
